/* common/fxp_pkg.sv */
//----------------------------------------------------------------------
// Fixed-point divide unit shared definitions
// Q8.8 operand type, IEEE-754 single fields, the response word and
// the pipeline, FIFO and credit constants
//----------------------------------------------------------------------

package fxp_pkg;

  //----------------------------------------------------------------------
  // Number format
  //----------------------------------------------------------------------
  localparam int FXP_W = 16;
  localparam int FXP_FRAC = 8;

  // Float exponent bias
  localparam int FLT_BIAS = 127;

  //----------------------------------------------------------------------
  // Pipeline and flow control
  //----------------------------------------------------------------------
  // Magnitude stage, one stage per quotient bit, rounding, saturation
  localparam int DIV_LATENCY = 19;

  // Result FIFO entries, also the request credits after reset
  localparam int FIFO_DEPTH = 4;

  // Response credits held by the response stage after reset
  localparam int RSP_CREDITS = 2;

  //----------------------------------------------------------------------
  // Types
  //----------------------------------------------------------------------
  typedef logic signed [FXP_W-1:0] fxp_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } flt_t;

  // Fixed response, quotient in the low half
  typedef struct packed {
    logic [31-FXP_W:0] pad;
    fxp_t              q;
  } fxp_view_t;

  typedef union packed {
    fxp_view_t fxp;
    flt_t      flt;
  } rsp_word_u;

endpackage

/* fxp_div/fxp_div_pipe.sv */
//----------------------------------------------------------------------
// Pipelined Q8.8 restoring divider
// One stage per quotient bit, round to nearest and saturate to the
// Q8.8 range, new request accepted every cycle
//----------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_div_pipe (
  input  logic          clk,
  input  logic          rstn,
  input  logic          in_valid,
  input  logic          in_to_float,
  input  fxp_pkg::fxp_t dividend,
  input  fxp_pkg::fxp_t divisor,
  output logic          out_valid,
  output logic          out_to_float,
  output fxp_pkg::fxp_t quot,
  output logic          overflow
);

  import fxp_pkg::*;

  // Operand magnitudes, 0x8000 fits as unsigned
  logic [FXP_W-1:0] mag_a;
  logic [FXP_W-1:0] mag_b;

  // Stage index 0 holds the magnitudes, index k holds k quotient bits
  logic [FXP_W:0]            vld_q;
  logic [FXP_W:0]            tf_q;
  logic [FXP_W:0]            sgn_q;
  logic [FXP_W+FXP_FRAC-1:0] rem_q [0:FXP_W];
  logic [FXP_W-1:0]          dvs_q [0:FXP_W];
  logic [FXP_W-1:0]          res_q [0:FXP_W];

  // Divisor scaled to the weight of each quotient bit
  logic [2*FXP_W-1:0] trial [0:FXP_W-1];

  // Rounding stage
  logic             round_up;
  logic             rnd_vld;
  logic             rnd_tf;
  logic             rnd_sgn;
  logic [FXP_W:0]   rnd_mag;

  assign mag_a = dividend[FXP_W-1] ? -dividend : dividend;
  assign mag_b = divisor[FXP_W-1] ? -divisor : divisor;

  always_comb begin
    for (int i = 0; i < FXP_W; i++) begin
      trial[i] = {{FXP_W{1'b0}}, dvs_q[i]} << (FXP_W - 1 - i);
    end
  end

  // Remainder at least half the divisor
  assign round_up = {rem_q[FXP_W], 1'b0} >= {{(FXP_FRAC+1){1'b0}}, dvs_q[FXP_W]};

  //----------------------------------------------------------------------
  // Valid pipe
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_q     <= '0;
      rnd_vld   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      vld_q     <= {vld_q[FXP_W-1:0], in_valid};
      rnd_vld   <= vld_q[FXP_W];
      out_valid <= rnd_vld;
    end
  end

  //----------------------------------------------------------------------
  // Magnitude stage and quotient bit stages
  //----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    tf_q     <= {tf_q[FXP_W-1:0], in_to_float};
    sgn_q    <= {sgn_q[FXP_W-1:0], dividend[FXP_W-1] ^ divisor[FXP_W-1]};
    // Dividend scaled by 2^FXP_FRAC so the quotient lands in Q8.8
    rem_q[0] <= {mag_a, {FXP_FRAC{1'b0}}};
    dvs_q[0] <= mag_b;
    res_q[0] <= '0;
    for (int i = 0; i < FXP_W; i++) begin
      dvs_q[i+1] <= dvs_q[i];
      if (trial[i] <= {{(FXP_W-FXP_FRAC){1'b0}}, rem_q[i]}) begin
        rem_q[i+1] <= rem_q[i] - trial[i][FXP_W+FXP_FRAC-1:0];
        res_q[i+1] <= res_q[i] | ({1'b1, {(FXP_W-1){1'b0}}} >> i);
      end else begin
        rem_q[i+1] <= rem_q[i];
        res_q[i+1] <= res_q[i];
      end
    end
  end

  //----------------------------------------------------------------------
  // Round, then sign and saturate
  //----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    rnd_tf  <= tf_q[FXP_W];
    rnd_sgn <= sgn_q[FXP_W];
    // Extra bit catches a carry out of an all-ones quotient
    rnd_mag <= {1'b0, res_q[FXP_W]} + {{FXP_W{1'b0}}, round_up};

    out_to_float <= rnd_tf;
    if (rnd_sgn) begin
      if (rnd_mag > {2'b01, {(FXP_W-1){1'b0}}}) begin
        quot     <= {1'b1, {(FXP_W-1){1'b0}}};
        overflow <= 1'b1;
      end else begin
        quot     <= ~rnd_mag[FXP_W-1:0] + 1'b1;
        overflow <= 1'b0;
      end
    end else begin
      if (rnd_mag > {2'b00, {(FXP_W-1){1'b1}}}) begin
        quot     <= {1'b0, {(FXP_W-1){1'b1}}};
        overflow <= 1'b1;
      end else begin
        quot     <= rnd_mag[FXP_W-1:0];
        overflow <= 1'b0;
      end
    end
  end

endmodule

/* hdl/result_fifo.sv */
//----------------------------------------------------------------------
// Result FIFO
// Circular buffer of finished quotients with overflow and float
// option, head word visible combinationally
//----------------------------------------------------------------------
`timescale 1ns/1ps

module result_fifo (
  input  logic          clk,
  input  logic          rstn,
  input  logic          push,
  input  fxp_pkg::fxp_t push_quot,
  input  logic          push_ovf,
  input  logic          push_to_float,
  input  logic          pop,
  output logic          not_empty,
  output fxp_pkg::fxp_t head_quot,
  output logic          head_ovf,
  output logic          head_to_float
);

  import fxp_pkg::*;

  // Storage
  fxp_t mem_quot [0:FIFO_DEPTH-1];
  logic mem_ovf  [0:FIFO_DEPTH-1];
  logic mem_tf   [0:FIFO_DEPTH-1];

  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;
  logic                            full;

  assign not_empty = (count != '0);
  assign full      = (count == FIFO_DEPTH);

  assign head_quot     = mem_quot[rd_ptr];
  assign head_ovf      = mem_ovf[rd_ptr];
  assign head_to_float = mem_tf[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_quot[wr_ptr] <= push_quot;
      mem_ovf[wr_ptr]  <= push_ovf;
      mem_tf[wr_ptr]   <= push_to_float;
    end
  end

  //----------------------------------------------------------------------
  // Pointers and occupancy
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/float_pack.sv */
//----------------------------------------------------------------------
// Response stage
// Pops results while response credits last, packs the fixed word or
// the IEEE-754 single, and returns one request credit per response
//----------------------------------------------------------------------
`timescale 1ns/1ps

module float_pack (
  input  logic               clk,
  input  logic               rstn,
  input  logic               not_empty,
  input  fxp_pkg::fxp_t      head_quot,
  input  logic               head_ovf,
  input  logic               head_to_float,
  input  logic               rsp_credit,
  output logic               pop,
  output logic               req_credit,
  output logic               rsp_valid,
  output fxp_pkg::rsp_word_u rsp_data,
  output logic               rsp_overflow
);

  import fxp_pkg::*;

  logic [$clog2(RSP_CREDITS+1)-1:0] cred;

  // Normalize
  logic [FXP_W-1:0]         mag;
  logic [$clog2(FXP_W)-1:0] lead_pos;
  logic [23:0]              norm;
  logic [7:0]               flt_exp;
  rsp_word_u                word;

  assign pop = not_empty && (cred != '0);

  assign mag = head_quot[FXP_W-1] ? -head_quot : head_quot;

  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < FXP_W; i++) begin
      if (mag[i]) begin
        lead_pos = ($clog2(FXP_W))'(i);
      end
    end
  end

  // Hidden one lands on bit 23, the fraction follows below it
  assign norm    = {{(24-FXP_W){1'b0}}, mag} << (23 - lead_pos);
  assign flt_exp = 8'(FLT_BIAS - FXP_FRAC) + 8'(lead_pos);

  always_comb begin
    word = '0;
    if (!head_to_float) begin
      word.fxp.q = head_quot;
    end else if (mag != '0) begin
      word.flt.sign = head_quot[FXP_W-1];
      word.flt.exp  = flt_exp;
      word.flt.frac = norm[22:0];
    end
  end

  //----------------------------------------------------------------------
  // Credits and response register
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cred         <= ($clog2(RSP_CREDITS+1))'(RSP_CREDITS);
      rsp_valid    <= 1'b0;
      req_credit   <= 1'b0;
      rsp_overflow <= 1'b0;
    end else begin
      case ({rsp_credit, pop})
        2'b10:   cred <= cred + 1'b1;
        2'b01:   cred <= cred - 1'b1;
        default: cred <= cred;
      endcase
      rsp_valid    <= pop;
      req_credit   <= pop;
      rsp_overflow <= pop && head_ovf;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rsp_data <= word;
    end
  end

endmodule

/* hdl/fxp_div_unit.sv */
//----------------------------------------------------------------------
// Credit-controlled Q8.8 divide unit
// Divider pipeline feeds a result FIFO, which is drained by the
// response stage with optional IEEE-754 conversion
//----------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_div_unit (
  input  logic              clk,
  input  logic              rstn,
  input  logic              req_valid,
  input  logic              req_to_float,
  input  fxp_pkg::fxp_t     dividend,
  input  fxp_pkg::fxp_t     divisor,
  input  logic              rsp_credit,
  output logic              req_credit,
  output logic              rsp_valid,
  output fxp_pkg::rsp_word_u rsp_data,
  output logic              rsp_overflow
);

  import fxp_pkg::*;

  // Divider to FIFO
  logic div_valid;
  logic div_to_float;
  fxp_t div_quot;
  logic div_ovf;

  // FIFO to response stage
  logic fifo_pop;
  logic fifo_not_empty;
  fxp_t head_quot;
  logic head_ovf;
  logic head_to_float;

  //----------------------------------------------------------------------
  // Producer, buffer, consumer
  //----------------------------------------------------------------------
  fxp_div_pipe fxp_div_pipe_inst (
    .clk          (clk),
    .rstn         (rstn),
    .in_valid     (req_valid),
    .in_to_float  (req_to_float),
    .dividend     (dividend),
    .divisor      (divisor),
    .out_valid    (div_valid),
    .out_to_float (div_to_float),
    .quot         (div_quot),
    .overflow     (div_ovf)
  );

  result_fifo result_fifo_inst (
    .clk           (clk),
    .rstn          (rstn),
    .push          (div_valid),
    .push_quot     (div_quot),
    .push_ovf      (div_ovf),
    .push_to_float (div_to_float),
    .pop           (fifo_pop),
    .not_empty     (fifo_not_empty),
    .head_quot     (head_quot),
    .head_ovf      (head_ovf),
    .head_to_float (head_to_float)
  );

  float_pack float_pack_inst (
    .clk           (clk),
    .rstn          (rstn),
    .not_empty     (fifo_not_empty),
    .head_quot     (head_quot),
    .head_ovf      (head_ovf),
    .head_to_float (head_to_float),
    .rsp_credit    (rsp_credit),
    .pop           (fifo_pop),
    .req_credit    (req_credit),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_overflow  (rsp_overflow)
  );

endmodule

/* tb/fxp_div_unit_checker.sv */
//----------------------------------------------------------------------
// Result FIFO occupancy checker
// Bound into the result FIFO, flags overflow and underflow of the
// buffer and an occupancy above the FIFO depth
//----------------------------------------------------------------------
`timescale 1ns/1ps

module fxp_div_unit_checker (
  input logic                                   clk,
  input logic                                   rstn,
  input logic                                   push,
  input logic                                   pop,
  input logic                                   full,
  input logic [$clog2(fxp_pkg::FIFO_DEPTH+1)-1:0] count
);

  import fxp_pkg::*;

  // Request credits must keep the producer off a full buffer
  no_push_when_full: assert property (
    @(posedge clk) disable iff (!rstn) push |-> !full
  ) else $error("push into a full result FIFO");

  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rstn) pop |-> (count != '0)
  ) else $error("pop from an empty result FIFO");

  occupancy_in_range: assert property (
    @(posedge clk) disable iff (!rstn) count <= FIFO_DEPTH
  ) else $error("result FIFO occupancy above its depth");

endmodule

bind result_fifo fxp_div_unit_checker fxp_div_unit_checker_inst (
  .clk   (clk),
  .rstn  (rstn),
  .push  (push),
  .pop   (pop),
  .full  (full),
  .count (count)
);

/* tb/tb_fxp_div_unit.sv */
//----------------------------------------------------------------------
// Testbench for the credit-controlled Q8.8 divide unit
// Replays the stimulus vectors under both credit protocols and
// compares every response with the expected word from the file
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_fxp_div_unit;

  import fxp_pkg::*;

  // Response credits held back after reset release
  localparam int WITHHOLD = 60;

  logic      clk;
  logic      rstn;
  logic      req_valid;
  logic      req_to_float;
  fxp_t      dividend;
  fxp_t      divisor;
  logic      rsp_credit;
  logic      req_credit;
  logic      rsp_valid;
  rsp_word_u rsp_data;
  logic      rsp_overflow;

  // Vectors from the stimulus file
  string       vec_name [$];
  fxp_t        vec_a    [$];
  fxp_t        vec_b    [$];
  logic        vec_tf   [$];
  rsp_word_u   vec_word [$];
  logic        vec_ovf  [$];
  int          exp_idx  [$];

  int          fd;
  int          code;
  string       tok;
  string       line;
  logic [15:0] rd_a;
  logic [15:0] rd_b;
  logic        rd_tf;
  logic [31:0] rd_word;
  logic        rd_ovf;

  int          nvec;
  int          limit;
  int          cycle;
  int          issued;
  int          rsp_cnt;
  int          req_cred;
  int          owed;
  int          returned;
  int unsigned gap;
  int unsigned rnd;
  int          cur;
  int          pass_cnt;
  int          fail_cnt;
  int          err_cnt;

  fxp_div_unit fxp_div_unit_inst (
    .clk          (clk),
    .rstn         (rstn),
    .req_valid    (req_valid),
    .req_to_float (req_to_float),
    .dividend     (dividend),
    .divisor      (divisor),
    .rsp_credit   (rsp_credit),
    .req_credit   (req_credit),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .rsp_overflow (rsp_overflow)
  );

  always #20 clk = ~clk;

  //----------------------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------------------
  task automatic check_fxp(input string name, input fxp_t exp_q, input logic exp_ovf,
                           input fxp_t act_q, input logic act_ovf);
    if (act_q !== exp_q || act_ovf !== exp_ovf) begin
      $display("Fail %s: expected %h ovf %b, actual %h ovf %b",
               name, exp_q, exp_ovf, act_q, act_ovf);
      fail_cnt++;
    end else begin
      $display("Pass %s: %h ovf %b", name, act_q, act_ovf);
      pass_cnt++;
    end
  endtask

  task automatic check_flt(input string name, input flt_t exp_f, input logic exp_ovf,
                           input flt_t act_f, input logic act_ovf);
    if (act_f !== exp_f || act_ovf !== exp_ovf) begin
      $display("Fail %s: expected %h ovf %b, actual %h ovf %b",
               name, exp_f, exp_ovf, act_f, act_ovf);
      fail_cnt++;
    end else begin
      $display("Pass %s: %h ovf %b", name, act_f, act_ovf);
      pass_cnt++;
    end
  endtask

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    req_valid = 1'b0;
    req_to_float = 1'b0;
    dividend = '0;
    divisor = '0;
    rsp_credit = 1'b0;
    pass_cnt = 0;
    fail_cnt = 0;
    err_cnt = 0;
    rnd = $urandom(32'hb8dbcdae);

    // Lines starting with # are comments
    fd = $fopen("tb/fxp_div_stim.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the stimulus file");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h", rd_a, rd_b, rd_tf, rd_word, rd_ovf);
          if (code != 5) begin
            $display("Error: malformed stimulus line for %s", tok);
            err_cnt++;
            break;
          end
          vec_name.push_back(tok);
          vec_a.push_back(rd_a);
          vec_b.push_back(rd_b);
          vec_tf.push_back(rd_tf);
          vec_word.push_back(rd_word);
          vec_ovf.push_back(rd_ovf);
        end
      end
      $fclose(fd);
    end
    nvec = vec_name.size();
    limit = (nvec + 4) * (DIV_LATENCY + 8);

    repeat (8) @(posedge clk);
    #2 rstn = 1'b1;

    cycle = 0;
    issued = 0;
    rsp_cnt = 0;
    req_cred = FIFO_DEPTH;
    owed = 0;
    returned = 0;
    gap = rnd % 7;

    //----------------------------------------------------------------------
    // One pass per cycle, sample then drive
    //----------------------------------------------------------------------
    while (rsp_cnt < nvec && cycle < limit) begin
      @(posedge clk);
      #2;
      cycle++;
      if (cycle == 1 && (rsp_valid !== 1'b0 || req_credit !== 1'b0 || rsp_overflow !== 1'b0)) begin
        $display("Error: response outputs not low after reset");
        err_cnt++;
      end
      if (req_credit !== rsp_valid) begin
        $display("Error: request credit not paired with a response in cycle %0d", cycle);
        err_cnt++;
      end
      if (req_credit === 1'b1) req_cred++;
      if (rsp_valid === 1'b1) begin
        rsp_cnt++;
        owed++;
        if (rsp_cnt > RSP_CREDITS + returned) begin
          $display("Error: response sent without a response credit");
          err_cnt++;
        end
        if (exp_idx.size() == 0) begin
          $display("Error: response arrived with no request outstanding");
          err_cnt++;
        end else begin
          cur = exp_idx.pop_front();
          if (vec_tf[cur]) begin
            check_flt(vec_name[cur], vec_word[cur].flt, vec_ovf[cur], rsp_data.flt, rsp_overflow);
          end else begin
            check_fxp(vec_name[cur], vec_word[cur].fxp.q, vec_ovf[cur],
                      rsp_data.fxp.q, rsp_overflow);
            if (rsp_data.fxp.pad !== vec_word[cur].fxp.pad) begin
              $display("Fail %s: expected pad %h, actual pad %h",
                       vec_name[cur], vec_word[cur].fxp.pad, rsp_data.fxp.pad);
              err_cnt++;
            end
          end
        end
      end

      req_valid = 1'b0;
      if (req_cred > 0 && issued < nvec) begin
        req_valid = 1'b1;
        req_to_float = vec_tf[issued];
        dividend = vec_a[issued];
        divisor = vec_b[issued];
        exp_idx.push_back(issued);
        issued++;
        req_cred--;
      end

      // Response credits go back one at a time at random gaps
      rsp_credit = 1'b0;
      if (cycle >= WITHHOLD && owed > 0) begin
        if (gap == 0) begin
          rsp_credit = 1'b1;
          owed--;
          returned++;
          gap = $urandom % 7;
        end else begin
          gap--;
        end
      end
    end

    if (rsp_cnt < nvec) begin
      $display("Timeout: responses stopped arriving, %0d of %0d received", rsp_cnt, nvec);
      err_cnt++;
    end
    $display("Tests: %0d run, %0d passed, %0d failed, %0d protocol errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb/fxp_div_stim.txt */
# name dividend divisor to_float expected_word overflow (all hex)
# expected_word is the 32-bit response, fixed results have a zero pad
exact_fx 0300 0180 0 00000200 0
exact_fl 0300 0180 1 40000000 0
quarter_fx 0100 0400 0 00000040 0
quarter_fl 0100 0400 1 3E800000 0
seven_half_fx 0F00 0200 0 00000780 0
big_fl 7800 0100 1 42F00000 0
third_pp 0100 0300 0 00000055 0
third_np FF00 0300 0 0000FFAB 0
third_pn 0100 FD00 0 0000FFAB 0
third_nn FF00 FD00 0 00000055 0
two_thirds 0200 0300 0 000000AB 0
tie_pos 0001 0200 0 00000001 0
tie_neg FFFF 0200 0 0000FFFF 0
sat_pos 6400 0080 0 00007FFF 1
sat_edge 4000 0080 0 00007FFF 1
sat_neg 9C00 0080 0 00008000 1
neg_limit 8000 0100 0 00008000 0
sat_fl 6400 0080 1 42FFFE00 1
neg_fl FD00 0180 1 C0000000 0
frac_fl 0100 0300 1 3EAA0000 0
neg_frac_fl FE00 0300 1 BF2B0000 0
zero_fl 0000 0500 1 00000000 0
zero_fx 0000 FB00 0 00000000 0
tiny_fl 0001 0100 1 3B800000 0

/* vlog.f */
common/fxp_pkg.sv
fxp_div/fxp_div_pipe.sv
hdl/result_fifo.sv
hdl/float_pack.sv
hdl/fxp_div_unit.sv
tb/fxp_div_unit_checker.sv
tb/tb_fxp_div_unit.sv
